// ==== test/microrocDaq_tests.txt ====
# Columns: name header dac0 dac1 dac2 dacSel start end window pulses mode
# Decimal values; mode is load or sweep; pulses are per sweep step
loadBasic     165  512  341  682  0  0     0     10   0   load
loadEdges     255  1023 0    1023 0  0     0     10   0   load
sweepDac0     90   100  200  300  0  10    13    120  5   sweep
sweepDac1     60   1    2    3    1  500   502   160  8   sweep
sweepDac2     15   777  888  999  2  1020  1023  100  3   sweep
sweepSel3     129  11   22   33   3  40    42    200  12  sweep
sweepZero     7    0    0    0    0  5     6     80   0   sweep
sweepSingle   200  300  400  500  1  250   250   140  7   sweep
sweepReverse  33   44   55   66   2  20    10    100  4   sweep

// ==== microrocDaq.f ====
hw/microrocPkg.sv
hw/daqIfs.sv
hw/cmdDecoder.sv
hw/sweepFsm.sv
hw/scLoader.sv
hw/trigCounter.sv
hw/microrocDaqTop.sv
test/microrocDaq_checker.sv
test/tbMicrorocDaq.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tbMicrorocDaq
FILELIST = microrocDaq.f
OBJDIR   = obj_dir
PASS_MSG = STATUS: PASS

SRCS = $(shell cat $(FILELIST))
BIN  = $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJDIR)

// ==== test/tbMicrorocDaq.sv ====
`timescale 1ns/10ps
`default_nettype none

module tbMicrorocDaq import microrocPkg::*; ();

    logic      Clk;
    logic      rst;
    ctrlWord_t cmdWord;
    logic      cmdValid;
    logic      outTrig0b;
    logic      srRstb;
    logic      srCk;
    logic      srIn;
    ctrlWord_t dataWord;
    logic      dataValid;
    logic      sweepBusy;

    scFrame_t  frameQ[$];  // Frames rebuilt from SR_IN
    logic      rstQ[$];    // SR_RSTB pulse seen ahead of each frame
    ctrlWord_t wordQ[$];
    logic      busyQ[$];   // sweepBusy alongside each data word
    scFrame_t  shiftAcc;
    int        bitIdx = 0;
    logic      rstSeen = 1'b0;
    logic      prevSrCk = 1'b0;
    logic [15:0] lfsr = 16'd20296;
    string     curTest = "reset";
    int        checks = 0;
    int        errors = 0;
    int        testErrors = 0;
    int        testsRun = 0;
    int        testsFailed = 0;

    microrocDaqTop #(.SYNC_STAGES(2)) dut (
        .Clk       (Clk),
        .rst       (rst),
        .cmdWord   (cmdWord),
        .cmdValid  (cmdValid),
        .outTrig0b (outTrig0b),
        .srRstb    (srRstb),
        .srCk      (srCk),
        .srIn      (srIn),
        .dataWord  (dataWord),
        .dataValid (dataValid),
        .sweepBusy (sweepBusy)
    );

    initial begin
        Clk = 1'b0;
        forever #20 Clk = ~Clk;  // 40 ns period
    end

    //////////////////////////////////////////////////
    // Monitors, pre-edge values at posedge
    //////////////////////////////////////////////////
    always @(posedge Clk) begin
        if (rst) begin
            bitIdx   = 0;
            rstSeen  = 1'b0;
            prevSrCk = 1'b0;
        end else begin
            if (!srRstb)
                rstSeen = 1'b1;
            if (srCk && !prevSrCk) begin  // SR_CK rise, ASIC takes SR_IN
                if (bitIdx == 0) begin
                    rstQ.push_back(rstSeen);
                    rstSeen = 1'b0;
                end
                shiftAcc = {shiftAcc[SC_FRAME_BITS-2:0], srIn};  // MSB arrives first
                bitIdx++;
                if (bitIdx == SC_FRAME_BITS) begin
                    frameQ.push_back(shiftAcc);
                    bitIdx = 0;
                end
            end
            prevSrCk = srCk;
            if (dataValid) begin
                wordQ.push_back(dataWord);
                busyQ.push_back(sweepBusy);
            end
        end
    end

    // Galois LFSR, one step per bit
    function automatic logic lfsrBit();
        logic outBit;
        outBit = lfsr[0];
        lfsr = {1'b0, lfsr[15:1]};
        if (outBit)
            lfsr = lfsr ^ 16'hB400;
        return outBit;
    endfunction

    // Header then DAC0..DAC2, swept DAC overridden
    function automatic scFrame_t expectedFrame(input int hdr, input int d0, input int d1,
                                               input int d2, input int sel, input int code,
                                               input logic sweeping);
        int f0;
        int f1;
        int f2;
        f0 = d0;
        f1 = d1;
        f2 = d2;
        if (sweeping && sel == 0)
            f0 = code;
        else if (sweeping && sel == 1)
            f1 = code;
        else if (sweeping)
            f2 = code;  // Select 2 and 3 both hit DAC2
        return {header_t'(hdr), dacCode_t'(f0), dacCode_t'(f1), dacCode_t'(f2)};
    endfunction

    task automatic abortRun(input string why);
        $display("%0s: %0s", curTest, why);
        $display("STATUS: FAIL");
        $finish;
    endtask

    task automatic checkVal(input string what, input logic [63:0] expVal,
                            input logic [63:0] actVal);
        checks++;
        assert (expVal == actVal) else begin
            $display("** Error %0s %0s: expected %0h actual %0h", curTest, what, expVal, actVal);
            errors++;
            testErrors++;
        end
    endtask

    task automatic checkFlag(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("%0s: %0s", curTest, what);
            errors++;
            testErrors++;
        end
    endtask

    task automatic finishTest();
        testsRun++;
        if (testErrors != 0)
            testsFailed++;
        $display("test %0s: %0s (%0d errors)", curTest, testErrors == 0 ? "ok" : "FAILED",
                 testErrors);
        testErrors = 0;
    endtask

    task automatic sendCmd(input opcode_t op, input int arg);
        cmdWord  = {op, 12'(arg)};
        cmdValid = 1'b1;
        @(negedge Clk);
        cmdValid = 1'b0;
        cmdWord  = '0;
    endtask

    task automatic waitFrames(input int n, input int limit);
        int t;
        t = 0;
        while (frameQ.size() < n) begin
            @(negedge Clk);
            t++;
            if (t > limit)
                abortRun($sformatf("no slow-control frame %0d within %0d cycles", n, limit));
        end
    endtask

    task automatic waitWords(input int n, input int limit);
        int t;
        t = 0;
        while (wordQ.size() < n) begin
            @(negedge Clk);
            t++;
            if (t > limit)
                abortRun($sformatf("data word %0d never arrived", n));
        end
    endtask

    task automatic waitBusy(input logic level, input int limit);
        int t;
        t = 0;
        while (sweepBusy != level) begin
            @(negedge Clk);
            t++;
            if (t > limit)
                abortRun($sformatf("sweepBusy stuck at %0b", sweepBusy));
        end
    endtask

    // Low for 2 cycles, random high gap of 2 to 9
    task automatic drivePulses(input int n);
        int gap;
        for (int p = 0; p < n; p++) begin
            outTrig0b = 1'b0;
            repeat (2) @(negedge Clk);
            outTrig0b = 1'b1;
            gap = 2;
            for (int b = 0; b < 3; b++)
                gap += int'(lfsrBit()) << b;
            repeat (gap) @(negedge Clk);
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////
    initial begin
        int    fd;
        int    n;
        int    steps;
        int    hdr, d0, d1, d2, sel, startC, endC, win, pulses;
        logic  sawBusy;
        string line;
        string name;
        string mode;
        rst       = 1'b1;
        cmdWord   = '0;
        cmdValid  = 1'b0;
        outTrig0b = 1'b1;  // Trigger idles high
        repeat (10) @(negedge Clk);
        rst = 1'b0;
        @(negedge Clk);
        checkVal("srCk", 64'(0), 64'(srCk));
        checkVal("srRstb", 64'(1), 64'(srRstb));
        checkVal("dataValid", 64'(0), 64'(dataValid));
        checkVal("sweepBusy", 64'(0), 64'(sweepBusy));
        finishTest();

        fd = $fopen("test/microrocDaq_tests.txt", "r");
        if (fd == 0)
            abortRun("cannot open test/microrocDaq_tests.txt");
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %s", name, hdr, d0, d1, d2,
                        sel, startC, endC, win, pulses, mode);
            if (n != 11)
                continue;  // Comment or blank line
            curTest = name;
            frameQ.delete();
            rstQ.delete();
            wordQ.delete();
            busyQ.delete();
            sendCmd(OP_HEADER, hdr);
            sendCmd(OP_DAC0, d0);
            sendCmd(OP_DAC1, d1);
            sendCmd(OP_DAC2, d2);
            sendCmd(OP_START_DAC, startC);
            sendCmd(OP_END_DAC, endC);
            sendCmd(OP_WINDOW, win);
            if (mode == "load") begin
                sendCmd(OP_LOAD, 0);
                waitFrames(1, 300);
                checkVal("frame", 64'(expectedFrame(hdr, d0, d1, d2, sel, 0, 1'b0)),
                         64'(frameQ[0]));
                checkFlag(rstQ[0], "SR_RSTB never went low before the first SR_CK rise");
                checkVal("data words", 64'(0), 64'(wordQ.size()));
            end else if (startC > endC) begin
                sendCmd(OP_SWEEP, sel);
                sawBusy = 1'b0;
                repeat (20) begin
                    @(negedge Clk);
                    sawBusy |= sweepBusy;
                end
                checkFlag(!sawBusy, "reversed sweep raised sweepBusy");
                checkVal("frames", 64'(0), 64'(frameQ.size()));
                checkVal("data words", 64'(0), 64'(wordQ.size()));
            end else begin
                steps = endC - startC + 1;
                sendCmd(OP_SWEEP, sel);
                waitBusy(1'b1, 10);
                sendCmd(OP_LOAD, 0);  // Mid-sweep load, dropped by the FSM
                for (int s = 0; s < steps; s++) begin
                    waitFrames(s + 1, win + 400);
                    checkVal($sformatf("frame step %0d", s),
                             64'(expectedFrame(hdr, d0, d1, d2, sel, startC + s, 1'b1)),
                             64'(frameQ[s]));
                    checkFlag(rstQ[s], "SR_RSTB never went low before a step frame");
                    repeat (8) @(negedge Clk);  // Clear of the window start
                    drivePulses(pulses);
                    waitWords(2 * s + 2, win + 100);
                    checkVal($sformatf("code word %0d", s), 64'(startC + s), 64'(wordQ[2 * s]));
                    checkVal($sformatf("count word %0d", s), 64'(pulses),
                             64'(wordQ[2 * s + 1]));
                end
                waitBusy(1'b0, 20);
                checkFlag(busyQ[2 * steps - 1], "sweepBusy fell before the last data word");
                checkVal("frames", 64'(steps), 64'(frameQ.size()));
                checkVal("data words", 64'(2 * steps), 64'(wordQ.size()));
            end
            finishTest();
        end
        $fclose(fd);

        $display("tests %0d failed %0d checks %0d errors %0d", testsRun, testsFailed, checks,
                 errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/microrocDaq_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module microrocDaq_checker (
    input logic Clk,
    input logic rst,
    input logic srRstb,
    input logic srCk,
    input logic dataValid,
    input logic loadReq,
    input logic loadDone
);

    // No shift clock while the ASIC register is in reset
    assert property (@(posedge Clk) disable iff (rst) $rose(srCk) |-> srRstb)
        else $error("SR_CK rose with SR_RSTB low");

    // Code word plus count word, never a third
    assert property (@(posedge Clk) disable iff (rst) dataValid && $past(dataValid) |=> !dataValid)
        else $error("dataValid high for more than 2 cycles");

    assert property (@(posedge Clk) disable iff (rst) loadReq |-> ##79 loadDone)
        else $error("loadDone not 79 cycles after loadReq");

endmodule

bind microrocDaqTop microrocDaq_checker chk (
    .Clk       (Clk),
    .rst       (rst),
    .srRstb    (srRstb),
    .srCk      (srCk),
    .dataValid (dataValid),
    .loadReq   (scBus.loadReq),
    .loadDone  (scBus.loadDone)
);

`default_nettype wire

// ==== hw/microrocDaqTop.sv ====
`timescale 1ns/10ps
`default_nettype none

module microrocDaqTop import microrocPkg::*; #(
    parameter int SYNC_STAGES = 2  // Trigger synchronizer depth, 2 or more
) (
    input  logic      Clk,
    input  logic      rst,
    input  ctrlWord_t cmdWord,
    input  logic      cmdValid,
    input  logic      outTrig0b,
    output logic      srRstb,
    output logic      srCk,
    output logic      srIn,
    output ctrlWord_t dataWord,
    output logic      dataValid,
    output logic      sweepBusy
);

    header_t    header;
    dacCode_t   dac0;
    dacCode_t   dac1;
    dacCode_t   dac2;
    dacCode_t   startDac;
    dacCode_t   endDac;
    windowLen_t windowLen;
    dacSel_t    dacSel;
    logic       loadStrobe;
    logic       sweepStart;

    scLoadIf    scBus ();
    trigCountIf tcBus ();

    //////////////////////////////////////////////////
    // USB command side
    //////////////////////////////////////////////////
    cmdDecoder cmdDec (
        .Clk        (Clk),
        .rst        (rst),
        .cmdWord    (cmdWord),
        .cmdValid   (cmdValid),
        .header     (header),
        .dac0       (dac0),
        .dac1       (dac1),
        .dac2       (dac2),
        .startDac   (startDac),
        .endDac     (endDac),
        .windowLen  (windowLen),
        .dacSel     (dacSel),
        .loadStrobe (loadStrobe),
        .sweepStart (sweepStart)
    );

    sweepFsm sweepCtrl (
        .Clk        (Clk),
        .rst        (rst),
        .header     (header),
        .dac0       (dac0),
        .dac1       (dac1),
        .dac2       (dac2),
        .startDac   (startDac),
        .endDac     (endDac),
        .windowLen  (windowLen),
        .dacSel     (dacSel),
        .loadStrobe (loadStrobe),
        .sweepStart (sweepStart),
        .sc         (scBus.master),
        .tc         (tcBus.master),
        .dataWord   (dataWord),
        .dataValid  (dataValid),
        .sweepBusy  (sweepBusy)
    );

    //////////////////////////////////////////////////
    // ASIC pin side
    //////////////////////////////////////////////////
    scLoader scLoad (
        .Clk    (Clk),
        .rst    (rst),
        .sc     (scBus.slave),
        .srRstb (srRstb),   // SR_RSTB
        .srCk   (srCk),     // SR_CK
        .srIn   (srIn)      // SR_IN
    );

    trigCounter #(
        .SYNC_STAGES (SYNC_STAGES)
    ) trigCnt (
        .Clk       (Clk),
        .rst       (rst),
        .outTrig0b (outTrig0b),  // OUT_TRIG0B
        .tc        (tcBus.slave)
    );

endmodule

`default_nettype wire

// ==== hw/trigCounter.sv ====
`timescale 1ns/10ps
`default_nettype none

module trigCounter import microrocPkg::*; #(
    parameter int SYNC_STAGES = 2
) (
    input  logic      Clk,
    input  logic      rst,
    input  logic      outTrig0b,  // Asynchronous, active low
    trigCountIf.slave tc
);

    logic [SYNC_STAGES:0] trigSync;  // Top bit is the previous synced sample
    logic                 trigFall;
    logic                 active;    // Window open
    windowLen_t           timer;
    countVal_t            count;

    assign trigFall = trigSync[SYNC_STAGES] & ~trigSync[SYNC_STAGES-1];

    assign tc.done  = active && timer == '0;  // windowLen+1 cycles after start
    assign tc.count = count;

    // Idle-high trigger synchronizer
    always_ff @(posedge Clk) begin
        if (rst)
            trigSync <= '1;
        else
            trigSync <= {trigSync[SYNC_STAGES-1:0], outTrig0b};
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            active <= 1'b0;
            timer  <= '0;
            count  <= '0;
        end else if (tc.start) begin
            active <= 1'b1;
            timer  <= tc.windowLen;
            count  <= '0;
        end else if (active) begin
            if (timer == '0)
                active <= 1'b0;
            else
                timer <= timer - 1'b1;
            if (trigFall && count != '1)
                count <= count + 1'b1;  // Saturates at full scale
        end
    end

endmodule

`default_nettype wire

// ==== hw/scLoader.sv ====
`timescale 1ns/10ps
`default_nettype none

module scLoader import microrocPkg::*; (
    input  logic   Clk,
    input  logic   rst,
    scLoadIf.slave sc,
    output logic   srRstb,
    output logic   srCk,
    output logic   srIn
);

    localparam logic [5:0] LAST_BIT = 6'(SC_FRAME_BITS - 1);

    scFrame_t   shiftReg;  // MSB goes out first
    logic       busy;
    logic       rstPhase;  // SR_RSTB held low
    logic       phase;     // 0 setup with SR_CK low, 1 SR_CK high
    logic [5:0] bitCnt;
    logic       loadDone;
    logic       takeBit;   // Next MSB moves onto SR_IN

    assign takeBit = busy && phase && (rstPhase || bitCnt != LAST_BIT);

    assign sc.busy     = busy;
    assign sc.loadDone = loadDone;

    always_ff @(posedge Clk) begin
        if (rst) begin
            busy     <= 1'b0;
            rstPhase <= 1'b0;
            phase    <= 1'b0;
            bitCnt   <= '0;
            loadDone <= 1'b0;
            srRstb   <= 1'b1;
            srCk     <= 1'b0;
            srIn     <= 1'b0;
        end else begin
            loadDone <= 1'b0;
            if (!busy) begin
                if (sc.loadReq) begin
                    busy     <= 1'b1;
                    rstPhase <= 1'b1;
                    phase    <= 1'b0;
                    srRstb   <= 1'b0;  // Two cycles of register reset
                end
            end else if (rstPhase) begin
                phase <= ~phase;
                if (phase) begin
                    rstPhase <= 1'b0;
                    srRstb   <= 1'b1;
                    bitCnt   <= '0;
                end
            end else if (!phase) begin
                srCk  <= 1'b1;         // ASIC samples on this rise
                phase <= 1'b1;
            end else begin
                srCk  <= 1'b0;
                phase <= 1'b0;
                if (bitCnt == LAST_BIT) begin
                    busy     <= 1'b0;
                    loadDone <= 1'b1;  // 79 cycles after loadReq
                end else begin
                    bitCnt <= bitCnt + 1'b1;
                end
            end
            if (takeBit)
                srIn <= shiftReg[SC_FRAME_BITS-1];
        end
    end

    always_ff @(posedge Clk) begin
        if (!busy && sc.loadReq)
            shiftReg <= sc.frame;
        else if (takeBit)
            shiftReg <= shiftReg << 1;
    end

endmodule

`default_nettype wire

// ==== hw/sweepFsm.sv ====
`timescale 1ns/10ps
`default_nettype none

module sweepFsm import microrocPkg::*; (
    input  logic       Clk,
    input  logic       rst,
    input  header_t    header,
    input  dacCode_t   dac0,
    input  dacCode_t   dac1,
    input  dacCode_t   dac2,
    input  dacCode_t   startDac,
    input  dacCode_t   endDac,
    input  windowLen_t windowLen,
    input  dacSel_t    dacSel,
    input  logic       loadStrobe,
    input  logic       sweepStart,
    scLoadIf.master    sc,
    trigCountIf.master tc,
    output ctrlWord_t  dataWord,
    output logic       dataValid,
    output logic       sweepBusy
);

    sweepState_t state;
    dacCode_t    curCode;   // Code of the current step
    dacCode_t    endCode;   // Latched at sweep start
    dacSel_t     selDac;
    countVal_t   countReg;  // Held for the second data word
    scFrame_t    frameReg;

    // Frame from the live registers with the selected DAC replaced while sweeping
    function automatic scFrame_t buildFrame(input logic sweeping);
        dacCode_t d0;
        dacCode_t d1;
        dacCode_t d2;
        d0 = dac0;
        d1 = dac1;
        d2 = dac2;
        if (sweeping) begin
            case (selDac)
                2'd0:    d0 = curCode;
                2'd1:    d1 = curCode;
                default: d2 = curCode;  // 3 falls onto DAC2
            endcase
        end
        return {header, d0, d1, d2};
    endfunction

    assign sc.frame     = frameReg;
    assign tc.windowLen = windowLen;

    //////////////////////////////////////////////////
    // Load, count, emit loop
    //////////////////////////////////////////////////
    always_ff @(posedge Clk) begin
        if (rst) begin
            state      <= IDLE;
            sweepBusy  <= 1'b0;
            sc.loadReq <= 1'b0;
            tc.start   <= 1'b0;
            dataValid  <= 1'b0;
        end else begin
            sc.loadReq <= 1'b0;
            tc.start   <= 1'b0;
            dataValid  <= 1'b0;
            case (state)
                IDLE: begin
                    if (loadStrobe) begin
                        state <= LOAD;            // Manual load leaves sweepBusy low
                    end else if (sweepStart && startDac <= endDac) begin
                        sweepBusy <= 1'b1;
                        state     <= LOAD;
                    end                           // Reversed range dropped
                end
                LOAD: if (!sc.busy) begin
                    sc.loadReq <= 1'b1;           // Only to an idle serializer
                    state      <= WAIT_LOAD;
                end
                WAIT_LOAD: if (sc.loadDone) begin
                    if (sweepBusy) begin
                        tc.start <= 1'b1;
                        state    <= COUNT;
                    end else begin
                        state <= IDLE;
                    end
                end
                COUNT: if (tc.done) begin
                    dataWord  <= ctrlWord_t'(curCode);  // Zero-extended code word
                    dataValid <= 1'b1;
                    state     <= EMIT_CODE;
                end
                EMIT_CODE: begin
                    dataWord  <= countReg;
                    dataValid <= 1'b1;
                    state     <= EMIT_COUNT;
                end
                EMIT_COUNT: begin
                    if (curCode == endCode) begin
                        sweepBusy <= 1'b0;        // Last step done
                        state     <= IDLE;
                    end else begin
                        state <= LOAD;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Step data and the frame handed to the serializer
    always_ff @(posedge Clk) begin
        if (state == IDLE && sweepStart) begin
            curCode <= startDac;
            endCode <= endDac;
            selDac  <= dacSel;
        end
        if (state == LOAD)
            frameReg <= buildFrame(sweepBusy);    // Stable until loadDone
        if (state == COUNT && tc.done)
            countReg <= tc.count;
        if (state == EMIT_COUNT && curCode != endCode)
            curCode <= curCode + 1'b1;
    end

endmodule

`default_nettype wire

// ==== hw/cmdDecoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module cmdDecoder import microrocPkg::*; (
    input  logic       Clk,
    input  logic       rst,
    input  ctrlWord_t  cmdWord,
    input  logic       cmdValid,
    output header_t    header,
    output dacCode_t   dac0,
    output dacCode_t   dac1,
    output dacCode_t   dac2,
    output dacCode_t   startDac,
    output dacCode_t   endDac,
    output windowLen_t windowLen,
    output dacSel_t    dacSel,
    output logic       loadStrobe,
    output logic       sweepStart
);

    opcode_t     opcode;
    logic [11:0] arg;   // Lower 12 bits, truncated per target

    assign opcode = cmdWord[15:12];
    assign arg    = cmdWord[11:0];

    always_ff @(posedge Clk) begin
        if (rst) begin
            header     <= '0;
            dac0       <= '0;
            dac1       <= '0;
            dac2       <= '0;
            startDac   <= '0;
            endDac     <= '0;
            windowLen  <= '0;
            dacSel     <= '0;
            loadStrobe <= 1'b0;
            sweepStart <= 1'b0;
        end else begin
            loadStrobe <= 1'b0;  // Strobes last one cycle
            sweepStart <= 1'b0;
            if (cmdValid) begin
                case (opcode)
                    OP_HEADER:    header    <= header_t'(arg);
                    OP_DAC0:      dac0      <= dacCode_t'(arg);
                    OP_DAC1:      dac1      <= dacCode_t'(arg);
                    OP_DAC2:      dac2      <= dacCode_t'(arg);
                    OP_START_DAC: startDac  <= dacCode_t'(arg);
                    OP_END_DAC:   endDac    <= dacCode_t'(arg);
                    OP_WINDOW:    windowLen <= arg;
                    OP_LOAD:      loadStrobe <= 1'b1;
                    OP_SWEEP: begin
                        dacSel     <= arg[1:0];  // Ready in the same cycle as the strobe
                        sweepStart <= 1'b1;
                    end
                    default: ;  // Unknown opcode dropped
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/daqIfs.sv ====
`timescale 1ns/10ps
`default_nettype none

// Frame handoff from the sweep FSM to the slow-control serializer
interface scLoadIf import microrocPkg::*; ();
    scFrame_t frame;     // Held stable until loadDone
    logic     loadReq;   // One-cycle request, only while busy is low
    logic     busy;
    logic     loadDone;  // One-cycle strobe at the end of the shift

    modport master (
        output frame, loadReq,
        input  busy, loadDone
    );

    modport slave (
        input  frame, loadReq,
        output busy, loadDone
    );
endinterface

// Count window request and result
interface trigCountIf import microrocPkg::*; ();
    logic       start;      // Opens a window, clears the count
    windowLen_t windowLen;
    logic       done;       // Window closed
    countVal_t  count;      // Valid with done

    modport master (
        output start, windowLen,
        input  done, count
    );

    modport slave (
        input  start, windowLen,
        output done, count
    );
endinterface

`default_nettype wire

// ==== hw/microrocPkg.sv ====
`default_nettype none

package microrocPkg;

    ////////////////////////////////////////////////
    // Widths with a meaning of their own
    ////////////////////////////////////////////////
    typedef logic [15:0] ctrlWord_t;   // USB control word or data word
    typedef logic [3:0]  opcode_t;     // Upper nibble of a control word
    typedef logic [9:0]  dacCode_t;    // 10-bit threshold DAC
    typedef logic [7:0]  header_t;     // ASIC header
    typedef logic [15:0] countVal_t;   // Saturating trigger count
    typedef logic [11:0] windowLen_t;  // Count window in Clk cycles
    typedef logic [1:0]  dacSel_t;     // 3 behaves as DAC2

    // Slow-control frame, header then DAC0..DAC2 from the MSB down
    localparam int SC_FRAME_BITS = 38;
    typedef logic [SC_FRAME_BITS-1:0] scFrame_t;

    ////////////////////////////////////////////////
    // Command opcodes
    ////////////////////////////////////////////////
    localparam opcode_t OP_HEADER    = 4'd1;
    localparam opcode_t OP_DAC0      = 4'd2;
    localparam opcode_t OP_DAC1      = 4'd3;
    localparam opcode_t OP_DAC2      = 4'd4;
    localparam opcode_t OP_START_DAC = 4'd5;
    localparam opcode_t OP_END_DAC   = 4'd6;
    localparam opcode_t OP_WINDOW    = 4'd7;
    localparam opcode_t OP_LOAD      = 4'd8;  // Manual slow-control load
    localparam opcode_t OP_SWEEP     = 4'd9;  // Threshold sweep, arg[1:0] picks the DAC

    // Sweep controller states
    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        WAIT_LOAD,
        COUNT,
        EMIT_CODE,
        EMIT_COUNT
    } sweepState_t;

endpackage

`default_nettype wire
